/* hw/vga_pkg.sv */
package vga_pkg;

    // Coordinate and colour widths of the frame buffer port
    localparam int X_W      = 8;
    localparam int Y_W      = 7;
    localparam int COLOUR_W = 3;

    // Visible screen size in pixels
    localparam int SCREEN_W_DEFAULT = 160;
    localparam int SCREEN_H_DEFAULT = 120;

    // One pixel write towards the frame buffer
    // plot is the write strobe, the other fields are only meaningful while it is high
    typedef struct packed {
        logic [X_W-1:0]      x;
        logic [Y_W-1:0]      y;
        logic [COLOUR_W-1:0] colour;
        logic                plot;
    } pixel_t;

endpackage

/* hw/circle_pkg.sv */
package circle_pkg;

    // Signed offset width, one bit above the 8-bit radius
    localparam int OFS_W  = 9;

    // Signed decision variable width
    localparam int CRIT_W = 10;

    // Circle request as issued with draw_start
    typedef struct packed {
        logic [vga_pkg::X_W-1:0]      centre_x;
        logic [vga_pkg::Y_W-1:0]      centre_y;
        logic [7:0]                   radius;
        logic [vga_pkg::COLOUR_W-1:0] colour;
    } circle_req_t;

    // First octant offset pair, ofs_x >= ofs_y while a point is valid
    typedef struct packed {
        logic signed [OFS_W-1:0] ofs_x;
        logic signed [OFS_W-1:0] ofs_y;
    } offset_t;

endpackage

/* hw/circle_stepper.sv */
module circle_stepper (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    start,
    input  circle_pkg::circle_req_t req_in,
    input  logic                    point_taken,
    output circle_pkg::circle_req_t req,
    output circle_pkg::offset_t     ofs,
    output logic                    point_valid,
    output logic                    busy,
    output logic                    done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_EMIT,
        S_UPDATE
    } state_t;

    state_t state;

    logic signed [circle_pkg::CRIT_W-1:0] crit;
    logic signed [circle_pkg::CRIT_W-1:0] next_crit;
    logic signed [circle_pkg::CRIT_W-1:0] step;
    logic signed [circle_pkg::OFS_W-1:0]  next_x;
    logic signed [circle_pkg::OFS_W-1:0]  next_y;
    logic                                 finish;

    // Midpoint step, y always moves, x moves when the decision is positive
    always_comb begin
        next_y = ofs.ofs_y + circle_pkg::OFS_W'(1);
        if (crit <= 0) begin
            next_x = ofs.ofs_x;
            step   = circle_pkg::CRIT_W'(next_y);
        end else begin
            next_x = ofs.ofs_x - circle_pkg::OFS_W'(1);
            step   = circle_pkg::CRIT_W'(next_y) - circle_pkg::CRIT_W'(next_x);
        end
        next_crit = crit + (step <<< 1) + circle_pkg::CRIT_W'(1);
        // Octant boundary crossed
        finish    = next_y > next_x;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_IDLE;
            ofs   <= '0;
            crit  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        ofs.ofs_x <= circle_pkg::OFS_W'(req_in.radius);
                        ofs.ofs_y <= '0;
                        crit      <= circle_pkg::CRIT_W'(1)
                                   - $signed(circle_pkg::CRIT_W'(req_in.radius));
                        state     <= S_EMIT;
                    end
                end
                S_EMIT: begin
                    // Offsets stay put until the sequencer has drained all octants
                    if (point_taken) begin
                        state <= S_UPDATE;
                    end
                end
                S_UPDATE: begin
                    ofs.ofs_x <= next_x;
                    ofs.ofs_y <= next_y;
                    crit      <= next_crit;
                    if (finish) begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end else begin
                        state <= S_EMIT;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request is held for the mappers for the whole draw
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            req <= req_in;
        end
    end

    assign point_valid = (state == S_EMIT);
    assign busy        = (state != S_IDLE);

endmodule

/* hw/octant_mapper.sv */
module octant_mapper #(
    parameter int OCTANT   = 0,
    parameter int SCREEN_W = vga_pkg::SCREEN_W_DEFAULT,
    parameter int SCREEN_H = vga_pkg::SCREEN_H_DEFAULT
) (
    input  circle_pkg::circle_req_t  req,
    input  circle_pkg::offset_t      ofs,
    output logic [vga_pkg::X_W-1:0]  x,
    output logic [vga_pkg::Y_W-1:0]  y,
    output logic                     onscreen
);

    // One bit of headroom over the offsets covers centre plus radius
    localparam int P_W = circle_pkg::OFS_W + 1;

    logic signed [P_W-1:0] cx, cy, ox, oy;
    logic signed [P_W-1:0] px, py;
    logic                  x_ok, y_ok;

    assign cx = $signed(P_W'(req.centre_x));
    assign cy = $signed(P_W'(req.centre_y));
    assign ox = P_W'(ofs.ofs_x);
    assign oy = P_W'(ofs.ofs_y);

    // Mirror table, octant 0 is the first octant itself
    always_comb begin
        case (OCTANT)
            0:       begin px = cx + ox; py = cy + oy; end
            1:       begin px = cx + oy; py = cy + ox; end
            2:       begin px = cx - oy; py = cy + ox; end
            3:       begin px = cx - ox; py = cy + oy; end
            4:       begin px = cx - ox; py = cy - oy; end
            5:       begin px = cx - oy; py = cy - ox; end
            6:       begin px = cx + oy; py = cy - ox; end
            default: begin px = cx + ox; py = cy - oy; end
        endcase
    end

    assign x_ok     = (px >= 0) && (px < SCREEN_W);
    assign y_ok     = (py >= 0) && (py < SCREEN_H);
    assign onscreen = x_ok && y_ok;
    assign x        = x_ok ? px[vga_pkg::X_W-1:0] : '0;
    assign y        = y_ok ? py[vga_pkg::Y_W-1:0] : '0;

endmodule

/* hw/pixel_sequencer.sv */
module pixel_sequencer (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               point_valid,
    input  circle_pkg::circle_req_t            req,
    input  logic [7:0][vga_pkg::X_W-1:0]       oct_x,
    input  logic [7:0][vga_pkg::Y_W-1:0]       oct_y,
    input  logic [7:0]                         oct_onscreen,
    output vga_pkg::pixel_t                    pix,
    output logic                               point_taken
);

    logic [2:0] cnt;

    // Octant counter, wraps back to 0 after octant 7
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt <= '0;
        end else if (point_valid) begin
            cnt <= cnt + 3'd1;
        end
    end

    // Last octant of the current point is being counted
    assign point_taken = point_valid && (cnt == 3'd7);

    // Output register, pixel follows its octant by one clock
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pix <= '0;
        end else begin
            pix.x      <= oct_x[cnt];
            pix.y      <= oct_y[cnt];
            pix.colour <= req.colour;
            pix.plot   <= point_valid && oct_onscreen[cnt];
        end
    end

endmodule

/* hw/fillscreen.sv */
module fillscreen #(
    parameter int SCREEN_W = vga_pkg::SCREEN_W_DEFAULT,
    parameter int SCREEN_H = vga_pkg::SCREEN_H_DEFAULT
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            start,
    output vga_pkg::pixel_t pix,
    output logic            busy,
    output logic            done
);

    logic [vga_pkg::X_W-1:0] x;
    logic [vga_pkg::Y_W-1:0] y;

    // Column by column, y is the inner counter
    always_ff @(posedge clk) begin
        if (!resetn) begin
            x    <= '0;
            y    <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    x    <= '0;
                    y    <= '0;
                    busy <= 1'b1;
                end
            end else if (y == vga_pkg::Y_W'(SCREEN_H - 1)) begin
                y <= '0;
                if (x == vga_pkg::X_W'(SCREEN_W - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
            end else begin
                y <= y + 1'b1;
            end
        end
    end

    // Counters drive the write directly, one pixel per busy cycle
    assign pix.x      = x;
    assign pix.y      = y;
    assign pix.colour = '0;
    assign pix.plot   = busy;

endmodule

/* hw/circle_draw_top.sv */
module circle_draw_top #(
    parameter int SCREEN_W = vga_pkg::SCREEN_W_DEFAULT,
    parameter int SCREEN_H = vga_pkg::SCREEN_H_DEFAULT
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    clear_start,
    input  logic                    draw_start,
    input  circle_pkg::circle_req_t req,
    output vga_pkg::pixel_t         pix,
    output logic                    busy,
    output logic                    done
);

    logic                           clear_go, draw_go;
    logic                           fill_busy, fill_done;
    logic                           draw_busy, draw_done;
    logic                           point_valid, point_taken;
    vga_pkg::pixel_t                pix_fill, pix_circle;
    circle_pkg::circle_req_t        cur_req;
    circle_pkg::offset_t            ofs;
    logic [7:0][vga_pkg::X_W-1:0]   oct_x;
    logic [7:0][vga_pkg::Y_W-1:0]   oct_y;
    logic [7:0]                     oct_onscreen;

    // Starts only while idle, clear has priority
    assign clear_go = clear_start && !busy;
    assign draw_go  = draw_start && !clear_start && !busy;

    fillscreen #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_fillscreen (
        .clk(clk), .resetn(resetn), .start(clear_go),
        .pix(pix_fill), .busy(fill_busy), .done(fill_done)
    );

    circle_stepper u_circle_stepper (
        .clk(clk), .resetn(resetn), .start(draw_go), .req_in(req),
        .point_taken(point_taken), .req(cur_req), .ofs(ofs),
        .point_valid(point_valid), .busy(draw_busy), .done(draw_done)
    );

    for (genvar i = 0; i < 8; i++) begin : g_oct
        octant_mapper #(.OCTANT(i), .SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) u_octant_mapper (
            .req(cur_req), .ofs(ofs),
            .x(oct_x[i]), .y(oct_y[i]), .onscreen(oct_onscreen[i])
        );
    end

    pixel_sequencer u_pixel_sequencer (
        .clk(clk), .resetn(resetn), .point_valid(point_valid), .req(cur_req),
        .oct_x(oct_x), .oct_y(oct_y), .oct_onscreen(oct_onscreen),
        .pix(pix_circle), .point_taken(point_taken)
    );

    // Sequencer output has plot low whenever no draw is running
    assign pix  = fill_busy ? pix_fill : pix_circle;
    assign busy = fill_busy | draw_busy;
    assign done = fill_done | draw_done;

endmodule

/* verification/circle_draw_checker.sv */
module circle_draw_checker (
    input logic            clk,
    input logic            resetn,
    input vga_pkg::pixel_t pix,
    input logic            busy,
    input logic            done
);

    localparam int SW = vga_pkg::SCREEN_W_DEFAULT;
    localparam int SH = vga_pkg::SCREEN_H_DEFAULT;

    // Every write lands inside the visible area
    a_plot_onscreen: assert property (@(posedge clk) disable iff (!resetn)
        pix.plot |-> (pix.x < vga_pkg::X_W'(SW)) && (pix.y < vga_pkg::Y_W'(SH)))
        else $error("plot with a coordinate outside the screen");

    a_done_single: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else $error("done held for more than one cycle");

    // Operation has ended once done is seen
    a_idle_after_done: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !busy)
        else $error("busy still high in the cycle after done");

    a_plot_needs_busy: assert property (@(posedge clk) disable iff (!resetn)
        pix.plot |-> busy)
        else $error("plot high while busy is low");

endmodule

/* verification/circle_draw_tb.sv */
module circle_draw_tb;

    localparam int SW     = vga_pkg::SCREEN_W_DEFAULT;
    localparam int SH     = vga_pkg::SCREEN_H_DEFAULT;
    localparam int N_RAND = 10;

    logic                    clk;
    logic                    resetn;
    logic                    clear_start;
    logic                    draw_start;
    circle_pkg::circle_req_t req;
    vga_pkg::pixel_t         pix;
    logic                    busy;
    logic                    done;

    bit                      bitmap [SW][SH];
    bit                      exp_map [SW][SH];
    vga_pkg::pixel_t         writes [$];
    vga_pkg::pixel_t         exp_writes [$];
    int                      done_count;
    int                      exp_points;
    int                      errors;
    int                      checks;
    int                      tests;
    int                      watch_cycles;
    logic [31:0]             rng;
    circle_pkg::circle_req_t rand_req [N_RAND];

    circle_draw_top #(.SCREEN_W(SW), .SCREEN_H(SH)) u_circle_draw_top (
        .clk(clk), .resetn(resetn), .clear_start(clear_start), .draw_start(draw_start),
        .req(req), .pix(pix), .busy(busy), .done(done)
    );

    bind circle_draw_top circle_draw_checker u_circle_draw_checker (
        .clk(clk), .resetn(resetn), .pix(pix), .busy(busy), .done(done)
    );

    always #50 clk = ~clk;

    // Scoreboard of every pixel write and every done pulse
    always @(negedge clk) begin
        if (resetn && pix.plot) begin
            if (pix.x >= SW || pix.y >= SH) begin
                errors++;
                $display("Pixel written outside the screen at x=%0d y=%0d, time %0t",
                         pix.x, pix.y, $time);
            end else begin
                bitmap[pix.x][pix.y] = 1'b1;
            end
            writes.push_back(pix);
        end
        if (resetn && done) begin
            done_count++;
        end
    end

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run is stuck", watch_cycles);
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic circle_pkg::circle_req_t make_req(input int cx, cy, r, c);
        circle_pkg::circle_req_t q;
        q.centre_x = vga_pkg::X_W'(cx);
        q.centre_y = vga_pkg::Y_W'(cy);
        q.radius   = 8'(r);
        q.colour   = vga_pkg::COLOUR_W'(c);
        return q;
    endfunction

    task automatic compare_pixel(input string name, input vga_pkg::pixel_t got,
                                 input vga_pkg::pixel_t exp);
        string got_s;
        string exp_s;
        checks++;
        if (got !== exp) begin
            errors++;
            got_s = $sformatf("x=%0d y=%0d colour=%0d plot=%0b",
                              got.x, got.y, got.colour, got.plot);
            exp_s = $sformatf("x=%0d y=%0d colour=%0d plot=%0b",
                              exp.x, exp.y, exp.colour, exp.plot);
            $display("FAIL %0t %s: got %s expected %s", $time, name, got_s, exp_s);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic reset_scoreboard();
        foreach (bitmap[i, j]) begin
            bitmap[i][j] = 1'b0;
        end
        writes.delete();
        done_count = 0;
    endtask

    // Clear order with y inner, x outer and colour 0 everywhere
    task automatic model_clear();
        vga_pkg::pixel_t p;
        exp_writes.delete();
        for (int x = 0; x < SW; x++) begin
            for (int y = 0; y < SH; y++) begin
                p = '{x: vga_pkg::X_W'(x), y: vga_pkg::Y_W'(y), colour: '0, plot: 1'b1};
                exp_writes.push_back(p);
                exp_map[x][y] = 1'b1;
            end
        end
    endtask

    // Midpoint walk of the first octant mirrored eight ways and clipped to the screen
    task automatic model_circle(input circle_pkg::circle_req_t r);
        int ox, oy, crit, cx, cy, px, py;
        vga_pkg::pixel_t p;
        exp_writes.delete();
        foreach (exp_map[i, j]) begin
            exp_map[i][j] = 1'b0;
        end
        cx = int'(r.centre_x);
        cy = int'(r.centre_y);
        ox = int'(r.radius);
        oy = 0;
        crit = 1 - ox;
        exp_points = 0;
        while (oy <= ox) begin
            exp_points++;
            for (int k = 0; k < 8; k++) begin
                case (k)
                    0: begin px = cx + ox; py = cy + oy; end
                    1: begin px = cx + oy; py = cy + ox; end
                    2: begin px = cx - oy; py = cy + ox; end
                    3: begin px = cx - ox; py = cy + oy; end
                    4: begin px = cx - ox; py = cy - oy; end
                    5: begin px = cx - oy; py = cy - ox; end
                    6: begin px = cx + oy; py = cy - ox; end
                    default: begin px = cx + ox; py = cy - oy; end
                endcase
                if (px >= 0 && px < SW && py >= 0 && py < SH) begin
                    p = '{x: px[7:0], y: py[6:0], colour: r.colour, plot: 1'b1};
                    exp_writes.push_back(p);
                    exp_map[px][py] = 1'b1;
                end
            end
            oy++;
            if (crit <= 0) begin
                crit += 2 * oy + 1;
            end else begin
                ox--;
                crit += 2 * (oy - ox) + 1;
            end
        end
    endtask

    task automatic check_writes();
        int mism;
        compare_count("write count", writes.size(), exp_writes.size());
        for (int i = 0; i < writes.size() && i < exp_writes.size(); i++) begin
            compare_pixel("pix", writes[i], exp_writes[i]);
        end
        mism = 0;
        foreach (bitmap[i, j]) begin
            if (bitmap[i][j] != exp_map[i][j]) begin
                mism++;
            end
        end
        compare_count("bitmap mismatches", mism, 0);
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!done && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            errors++;
            $display("No done pulse within %0d cycles at time %0t", limit, $time);
        end else begin
            compare_flag("busy", busy, 1'b0);
        end
        @(negedge clk);
    endtask

    task automatic run_clear();
        @(negedge clk);
        reset_scoreboard();
        clear_start = 1'b1;
        @(negedge clk);
        clear_start = 1'b0;
        compare_flag("busy", busy, 1'b1);
        wait_done(SW * SH + 10);
    endtask

    task automatic run_draw(input circle_pkg::circle_req_t r);
        @(negedge clk);
        reset_scoreboard();
        req = r;
        draw_start = 1'b1;
        @(negedge clk);
        draw_start = 1'b0;
        compare_flag("busy", busy, 1'b1);
        wait_done(9 * (int'(r.radius) + 1) + 10);
        model_circle(r);
        check_writes();
        compare_count("done pulses", done_count, 1);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_reset_idle();
        int e;
        e = errors;
        repeat (5) begin
            @(negedge clk);
            compare_flag("plot", pix.plot, 1'b0);
            compare_flag("busy", busy, 1'b0);
            compare_flag("done", done, 1'b0);
        end
        finish_test("reset idle", e);
    endtask

    task automatic test_clear();
        int e;
        e = errors;
        run_clear();
        model_clear();
        check_writes();
        compare_count("done pulses", done_count, 1);
        finish_test("clear screen", e);
    endtask

    task automatic test_circles();
        int e;
        e = errors;
        run_draw(make_req(80, 60, 20, 5));
        compare_count("write count", writes.size(), 8 * exp_points);
        run_draw(make_req(5, 110, 30, 3));
        run_draw(make_req(10, 10, 0, 6));
        compare_count("write count", writes.size(), 8);
        finish_test("directed circles", e);
    endtask

    // Draw request lands while the clear is running and must be dropped
    task automatic test_draw_during_clear();
        int e;
        e = errors;
        @(negedge clk);
        reset_scoreboard();
        clear_start = 1'b1;
        @(negedge clk);
        clear_start = 1'b0;
        repeat (3) @(negedge clk);
        req = make_req(80, 60, 20, 7);
        draw_start = 1'b1;
        @(negedge clk);
        draw_start = 1'b0;
        wait_done(SW * SH + 10);
        repeat (20) @(negedge clk);
        model_clear();
        check_writes();
        compare_count("done pulses", done_count, 1);
        compare_flag("busy", busy, 1'b0);
        finish_test("draw during clear", e);
    endtask

    task automatic test_random_circles();
        int e;
        e = errors;
        for (int i = 0; i < N_RAND; i++) begin
            run_clear();
            run_draw(rand_req[i]);
        end
        finish_test("random circles", e);
    endtask

    initial begin
        int limit;
        clk = 1'b0;
        resetn = 1'b0;
        clear_start = 1'b0;
        draw_start = 1'b0;
        req = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        rng = 32'd49622;
        limit = 12 * SW * SH + 9 * (20 + 1) + 9 * (30 + 1) + 9 * (0 + 1);
        for (int i = 0; i < N_RAND; i++) begin
            rng = xorshift32(rng);
            rand_req[i] = make_req(int'(rng[7:0]) % SW, int'(rng[14:8]) % SH,
                                   int'(rng[21:16]), int'(rng[26:24]));
            limit += 9 * (int'(rand_req[i].radius) + 1);
        end
        watch_cycles = 2 * limit;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        test_reset_idle();
        test_clear();
        test_circles();
        test_draw_during_clear();
        test_random_circles();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sources.f */
hw/vga_pkg.sv
hw/circle_pkg.sv
hw/circle_stepper.sv
hw/octant_mapper.sv
hw/pixel_sequencer.sv
hw/fillscreen.sv
hw/circle_draw_top.sv
verification/circle_draw_checker.sv
verification/circle_draw_tb.sv

/* run.sh */
#!/bin/sh
# Build the circle drawing testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module circle_draw_tb \
    -f sources.f -o circle_draw_sim &&
./obj_dir/circle_draw_sim | tee /dev/stderr | grep -q "Everything OK" &&
echo "simulation passed" || { echo "simulation did not pass"; exit 1; }
